//--- vlog.f
+incdir+verification
common/mem_map_pkg.sv
verilog/unified_ram.sv
verilog/hart_bus_router.sv
debug_apb/apb_request_master.sv
debug_apb/apb_port_arbiter.sv
verilog/mem_subsystem_top.sv
verification/tb_mem_subsystem.sv

//--- verification/tb_models.svh
/* Testbench models for the memory subsystem
   LFSR stimulus source, reference RAM, APB slave responder and expected reads */

`ifndef TB_MODELS_SVH
`define TB_MODELS_SVH

// ==================================================
// Random source
// ==================================================
// 16-bit Fibonacci LFSR with taps 16 14 13 11
logic [15:0] lfsr_state = 16'd57554;

function automatic logic next_random_bit();
  logic fb;
  fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
  lfsr_state = {lfsr_state[14:0], fb};
  return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] random_bits(input int n);
  logic [31:0] v;
  v = '0;
  for (int i = 0; i < n; i++)
    v = {v[30:0], next_random_bit()};
  return v;
endfunction

// ==================================================
// Reference RAM and expected read data
// ==================================================
logic [XLEN-1:0] ref_mem [RAM_WORDS];

// Debug window reads the responder pattern in debug mode only
// RAM and its alias index by the low 14 bits
// Everything else reads zero
function automatic logic [XLEN-1:0] expected_read(input logic [XLEN-1:0] addr, input logic dbg);
  logic [XLEN-1:0] val;
  if (dbg && (addr >= DEBUG_START) && (addr <= DEBUG_END))
    val = {19'b0, addr[12:0]} ^ 32'hA5A5_0000;
  else if (((addr >= 32'h0001_0000) && (addr < 32'h0001_4000)) || (addr[31:14] == 18'h3FFFF))
    val = ref_mem[addr[13:2]];
  else
    val = '0;
  return val;
endfunction

// ==================================================
// APB slave responder
// ==================================================
int unsigned           apb_xfers = 0;
logic [APB_AWIDTH-1:0] last_paddr;
logic                  last_pwrite;
logic [XLEN-1:0]       last_pwdata;

// Catches each setup cycle and answers with paddr XOR A5A50000
// Adds 0 to 3 random wait states
task automatic apb_responder();
  int                    waits;
  logic [APB_AWIDTH-1:0] addr;
  forever
  begin
    @(negedge clk);
    if (reset_n && o_apb.psel && !o_apb.penable)
    begin
      addr        = o_apb.paddr;
      last_paddr  = addr;
      last_pwrite = o_apb.pwrite;
      last_pwdata = o_apb.pwdata;
      apb_xfers++;
      waits = random_bits(2);
      // Access phase starts at the next edge and pready marks its last cycle
      repeat (waits + 1) @(posedge clk);
      i_apb <= '{pready: 1'b1, prdata: {19'b0, addr} ^ 32'hA5A5_0000, pslverr: 1'b0};
      // The completing cycle must be an access cycle
      @(negedge clk);
      check_value("APB penable in access phase", o_apb.penable, 1'b1);
      @(posedge clk);
      i_apb <= '0;
    end
  end
endtask

`endif

//--- verification/tb_mem_subsystem.sv
/* Testbench for the memory subsystem
   Random core traffic checked against a reference RAM and an APB slave model */

`timescale 1ns/100ps

module tb_mem_subsystem;
  import mem_map_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RESP_LIMIT   = 40;
  localparam int N_RAM        = 40;
  localparam int N_CONT       = 30;
  localparam int N_DBG        = 16;
  localparam int N_OFF        = 16;
  localparam int N_EXIT       = 5;
  // Contention runs both ports at once
  localparam int TOTAL_TXNS   = N_RAM + 2 * N_CONT + N_DBG + N_OFF + N_EXIT;

  logic            clk;
  logic            reset_n;
  fetch_req_t      i_fetch_req;
  data_req_t       i_data_req;
  logic            i_debug_mode;
  bus_resp_t       o_fetch_resp;
  bus_resp_t       o_data_resp;
  apb_m2s_t        o_apb;
  apb_s2m_t        i_apb;
  logic [XLEN-1:0] o_tohost;

  int errors          = 0;
  int tests_run       = 0;
  int tests_failed    = 0;
  int fetch_resp_seen = 0;
  int data_resp_seen  = 0;
  int written_idx [$];
  int pool_idx [$];
  bit in_pool [RAM_WORDS];

  `include "tb_models.svh"

  mem_subsystem_top UUT (
    .clk          (clk),
    .reset_n      (reset_n),
    .i_fetch_req  (i_fetch_req),
    .i_data_req   (i_data_req),
    .i_debug_mode (i_debug_mode),
    .o_fetch_resp (o_fetch_resp),
    .o_data_resp  (o_data_resp),
    .o_apb        (o_apb),
    .i_apb        (i_apb),
    .o_tohost     (o_tohost)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial apb_responder();

  // Count every response pulse for the one-response-per-request check
  always @(negedge clk)
  begin
    if (reset_n && o_fetch_resp.valid)
      fetch_resp_seen++;
    if (reset_n && o_data_resp.valid)
      data_resp_seen++;
  end

  // Watchdog sized from the transaction count
  initial
  begin
    #(CLK_PERIOD * (RESET_CYCLES + 20 * TOTAL_TXNS));
    $display("Timeout: tests did not finish within %0d cycles", RESET_CYCLES + 20 * TOTAL_TXNS);
    $display("Simulation failed");
    $finish;
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    assert (got === exp)
    else
    begin
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before)
      tests_failed++;
    $display("Test %s %s, %0d errors", name,
             (errors == errs_before) ? "passed" : "FAILED", errors - errs_before);
  endtask

  // Base region or alias region address of one RAM word
  function automatic logic [XLEN-1:0] ram_addr(input int idx, input logic use_alias);
    logic [XLEN-1:0] offs;
    offs = {18'b0, idx[RAM_AWIDTH-1:0], 2'b00};
    return use_alias ? {RAM_ALIAS_TAG, offs[13:0]} : RAM_BASE + offs;
  endfunction

  // Word address inside the debug window
  function automatic logic [XLEN-1:0] debug_addr();
    logic [XLEN-1:0] a;
    a = random_bits(10) << 2;
    if (a < DEBUG_START)
      a = a | DEBUG_START;
    return a;
  endfunction

  // Latency counts cycles from the edge where the router sees the request
  task automatic data_access(input logic wr, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata,
                             output int lat);
    int   n;
    logic got;
    @(posedge clk);
    i_data_req <= '{valid: 1'b1, write: wr, addr: addr, wdata: wdata};
    n   = 0;
    got = 1'b0;
    while (!got && (n < RESP_LIMIT))
    begin
      @(negedge clk);
      n++;
      got = o_data_resp.valid;
    end
    assert (got)
    else
    begin
      $display("No response on the data port for address %h", addr);
      errors++;
    end
    rdata = o_data_resp.rdata;
    lat   = n - 1;
    // Request drops on the edge after the response pulse
    @(posedge clk);
    i_data_req <= '0;
  endtask

  task automatic fetch_access(input logic [XLEN-1:0] addr, output logic [XLEN-1:0] rdata,
                              output int lat);
    int   n;
    logic got;
    @(posedge clk);
    i_fetch_req <= '{valid: 1'b1, addr: addr};
    n   = 0;
    got = 1'b0;
    while (!got && (n < RESP_LIMIT))
    begin
      @(negedge clk);
      n++;
      got = o_fetch_resp.valid;
    end
    assert (got)
    else
    begin
      $display("No response on the fetch port for address %h", addr);
      errors++;
    end
    rdata = o_fetch_resp.rdata;
    lat   = n - 1;
    @(posedge clk);
    i_fetch_req <= '0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial
  begin
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            wr;
    logic            use_fetch;
    int              lat;
    int              idx;
    int              e0;
    int              n0;
    int              f_base;
    int              d_base;

    i_fetch_req  = '0;
    i_data_req   = '0;
    i_debug_mode = 1'b0;
    i_apb        = '0;
    reset_n      = 1'b0;
    wdata        = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;

    e0 = errors;
    @(negedge clk);
    check_value("psel after reset", o_apb.psel, 1'b0);
    check_value("penable after reset", o_apb.penable, 1'b0);
    check_value("fetch valid after reset", o_fetch_resp.valid, 1'b0);
    check_value("data valid after reset", o_data_resp.valid, 1'b0);
    check_value("tohost after reset", o_tohost, '0);
    finish_test("reset_state", e0);

    // Writes through one region and reads back through either
    e0 = errors;
    for (int i = 0; i < N_RAM; i++)
    begin
      wr = (written_idx.size() == 0) || next_random_bit();
      if (wr)
      begin
        idx   = random_bits(RAM_AWIDTH);
        wdata = random_bits(32);
      end
      else
        idx = written_idx[random_bits(16) % written_idx.size()];
      addr = ram_addr(idx, next_random_bit());
      data_access(wr, addr, wdata, rdata, lat);
      if (wr)
      begin
        ref_mem[idx] = wdata;
        written_idx.push_back(idx);
      end
      else
        check_value("RAM data read", rdata, expected_read(addr, 1'b0));
      check_value("RAM data latency", lat, 2);
    end
    finish_test("ram_data_path", e0);

    // Fetches read a frozen pool while data writes stay outside it
    e0       = errors;
    pool_idx = written_idx;
    foreach (pool_idx[k])
      in_pool[pool_idx[k]] = 1'b1;
    f_base = fetch_resp_seen;
    d_base = data_resp_seen;
    fork
      begin
        int              fi;
        int              fl;
        logic [XLEN-1:0] fr;
        for (int i = 0; i < N_CONT; i++)
        begin
          fi = pool_idx[random_bits(16) % pool_idx.size()];
          fetch_access(ram_addr(fi, next_random_bit()), fr, fl);
          check_value("fetch read under contention", fr, ref_mem[fi]);
        end
      end
      begin
        int              di;
        int              dl;
        logic            dwr;
        logic [XLEN-1:0] dr;
        logic [XLEN-1:0] dw;
        dw = '0;
        for (int i = 0; i < N_CONT; i++)
        begin
          dwr = next_random_bit();
          if (dwr)
          begin
            di = random_bits(RAM_AWIDTH);
            // Step past pool words
            while (in_pool[di])
              di = (di + 1) % RAM_WORDS;
            dw = random_bits(32);
          end
          else
            di = pool_idx[random_bits(16) % pool_idx.size()];
          data_access(dwr, ram_addr(di, next_random_bit()), dw, dr, dl);
          if (dwr)
            ref_mem[di] = dw;
          else
            check_value("data read under contention", dr, ref_mem[di]);
        end
      end
    join
    repeat (4) @(negedge clk);
    check_value("fetch response count", fetch_resp_seen - f_base, N_CONT);
    check_value("data response count", data_resp_seen - d_base, N_CONT);
    finish_test("ram_contention", e0);

    // Debug window routed to the APB port on either hart port
    e0 = errors;
    @(posedge clk);
    i_debug_mode <= 1'b1;
    for (int i = 0; i < N_DBG; i++)
    begin
      addr      = debug_addr();
      use_fetch = next_random_bit();
      wr        = next_random_bit() && !use_fetch;
      wdata     = random_bits(32);
      n0        = apb_xfers;
      if (use_fetch)
        fetch_access(addr, rdata, lat);
      else
        data_access(wr, addr, wdata, rdata, lat);
      check_value("APB transfer count", apb_xfers - n0, 1);
      check_value("APB paddr", last_paddr, addr[APB_AWIDTH-1:0]);
      check_value("APB pwrite", last_pwrite, wr);
      if (wr)
        check_value("APB pwdata", last_pwdata, wdata);
      else
        check_value("debug read", rdata, expected_read(addr, 1'b1));
    end
    finish_test("debug_window_on", e0);

    // Debug window and far unmapped space both read zero with no APB traffic
    e0 = errors;
    @(posedge clk);
    i_debug_mode <= 1'b0;
    n0 = apb_xfers;
    for (int i = 0; i < N_OFF; i++)
    begin
      if (next_random_bit())
        addr = debug_addr();
      else
        addr = 32'h4000_0000 | (random_bits(24) << 2);
      use_fetch = next_random_bit();
      wr        = next_random_bit() && !use_fetch;
      wdata     = random_bits(32);
      if (use_fetch)
        fetch_access(addr, rdata, lat);
      else
        data_access(wr, addr, wdata, rdata, lat);
      if (!wr)
        check_value("unmapped read", rdata, expected_read(addr, 1'b0));
      check_value("unmapped latency", lat, 1);
    end
    check_value("APB transfers outside debug mode", apb_xfers - n0, 0);
    finish_test("debug_window_off", e0);

    e0 = errors;
    for (int i = 0; i < N_EXIT - 1; i++)
    begin
      wdata = random_bits(32);
      data_access(1'b1, TOHOST_ADDR, wdata, rdata, lat);
      check_value("exit write latency", lat, 1);
      check_value("tohost value", o_tohost, wdata);
    end
    // Write-only register reads back zero
    data_access(1'b0, TOHOST_ADDR, '0, rdata, lat);
    check_value("exit register read", rdata, '0);
    finish_test("tohost", e0);

    $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- verilog/mem_subsystem_top.sv
/* Memory subsystem top
   Router, shared RAM, debug APB requesters and the port arbiter */

`timescale 1ns/100ps

module mem_subsystem_top (
  input  logic                         clk,
  input  logic                         reset_n,
  input  mem_map_pkg::fetch_req_t      i_fetch_req,
  input  mem_map_pkg::data_req_t       i_data_req,
  input  logic                         i_debug_mode,
  output mem_map_pkg::bus_resp_t       o_fetch_resp,
  output mem_map_pkg::bus_resp_t       o_data_resp,
  output mem_map_pkg::apb_m2s_t        o_apb,
  input  mem_map_pkg::apb_s2m_t        i_apb,
  output logic [mem_map_pkg::XLEN-1:0] o_tohost
);
  import mem_map_pkg::*;

  ram_req_t                      ram_req;
  logic [XLEN-1:0]               fetch_rdata;
  logic                          fetch_rvalid;
  logic [XLEN-1:0]               data_rdata;
  logic                          data_rvalid;
  apb_req_t [NUM_APB_PORTS-1:0]  apb_req;
  bus_resp_t [NUM_APB_PORTS-1:0] apb_resp;
  apb_m2s_t [NUM_APB_PORTS-1:0]  apb_m2s;
  apb_s2m_t [NUM_APB_PORTS-1:0]  apb_s2m;
  logic [NUM_APB_PORTS-1:0]      apb_grant;

  hart_bus_router u_router (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_fetch_req    (i_fetch_req),
    .i_data_req     (i_data_req),
    .i_debug_mode   (i_debug_mode),
    .o_fetch_resp   (o_fetch_resp),
    .o_data_resp    (o_data_resp),
    .o_ram_req      (ram_req),
    .i_fetch_rdata  (fetch_rdata),
    .i_fetch_rvalid (fetch_rvalid),
    .i_data_rdata   (data_rdata),
    .i_data_rvalid  (data_rvalid),
    .o_apb_req      (apb_req),
    .i_apb_resp     (apb_resp),
    .o_tohost       (o_tohost)
  );

  unified_ram u_ram (
    .clk            (clk),
    .reset_n        (reset_n),
    .i_ram_req      (ram_req),
    .o_fetch_rdata  (fetch_rdata),
    .o_fetch_rvalid (fetch_rvalid),
    .o_data_rdata   (data_rdata),
    .o_data_rvalid  (data_rvalid)
  );

  // One requester per hart port, 0 fetch and 1 data
  for (genvar p = 0; p < NUM_APB_PORTS; p++)
  begin : g_apb_req
    apb_request_master u_master (
      .clk     (clk),
      .reset_n (reset_n),
      .i_req   (apb_req[p]),
      .o_resp  (apb_resp[p]),
      .o_apb   (apb_m2s[p]),
      .i_apb   (apb_s2m[p]),
      .i_grant (apb_grant[p])
    );
  end

  apb_port_arbiter u_arbiter (
    .clk       (clk),
    .reset_n   (reset_n),
    .i_apb_m2s (apb_m2s),
    .o_apb_s2m (apb_s2m),
    .o_grant   (apb_grant),
    .o_apb     (o_apb),
    .i_apb     (i_apb)
  );

endmodule

//--- debug_apb/apb_port_arbiter.sv
/* Debug APB port arbiter
   Fixed priority with data first, grant locked for a whole transfer */

`timescale 1ns/100ps

module apb_port_arbiter (
  input  logic                                                   clk,
  input  logic                                                   reset_n,
  input  mem_map_pkg::apb_m2s_t [mem_map_pkg::NUM_APB_PORTS-1:0] i_apb_m2s,
  output mem_map_pkg::apb_s2m_t [mem_map_pkg::NUM_APB_PORTS-1:0] o_apb_s2m,
  output logic [mem_map_pkg::NUM_APB_PORTS-1:0]                  o_grant,
  output mem_map_pkg::apb_m2s_t                                  o_apb,
  input  mem_map_pkg::apb_s2m_t                                  i_apb
);
  import mem_map_pkg::*;

  logic [NUM_APB_PORTS-1:0] owner_q;
  logic [NUM_APB_PORTS-1:0] pick;
  logic                     xfer_done;

  // ==================================================
  // Grant selection
  // ==================================================
  always_comb
  begin
    pick = '0;
    // Later index overrides, so the data port wins
    for (int p = 0; p < NUM_APB_PORTS; p++)
    begin
      if (i_apb_m2s[p].psel)
        pick = NUM_APB_PORTS'(1) << p;
    end
    o_grant = (|owner_q) ? owner_q : pick;
  end

  assign xfer_done = o_apb.penable && (i_apb.pready || i_apb.pslverr);

  // Lock from the setup cycle until the transfer ends
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      owner_q <= '0;
    else if (|owner_q)
    begin
      if (xfer_done)
        owner_q <= '0;
    end
    else
      owner_q <= pick;
  end

  // ==================================================
  // Bus mux and response routing
  // ==================================================
  always_comb
  begin
    o_apb = '0;
    for (int p = 0; p < NUM_APB_PORTS; p++)
    begin
      if (o_grant[p])
        o_apb = i_apb_m2s[p];
      // Waiting requesters never see pready
      o_apb_s2m[p] = o_grant[p] ? i_apb : '0;
    end
  end

  a_one_grant: assert property (@(posedge clk) disable iff (!reset_n)
    $onehot0(o_grant));

endmodule

//--- debug_apb/apb_request_master.sv
/* APB requester for one hart port
   Runs a held request as one setup/access transfer and returns the result */

`timescale 1ns/100ps

module apb_request_master (
  input  logic                   clk,
  input  logic                   reset_n,
  input  mem_map_pkg::apb_req_t  i_req,
  output mem_map_pkg::bus_resp_t o_resp,
  output mem_map_pkg::apb_m2s_t  o_apb,
  input  mem_map_pkg::apb_s2m_t  i_apb,
  input  logic                   i_grant
);
  import mem_map_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } apb_state_e;

  apb_state_e            state_q;
  logic [APB_AWIDTH-1:0] paddr_q;
  logic                  pwrite_q;
  logic [XLEN-1:0]       pwdata_q;
  logic                  resp_valid_q;
  logic [XLEN-1:0]       resp_rdata_q;
  logic                  xfer_done;

  // pslverr also ends the transfer
  assign xfer_done = (state_q == ST_ACCESS) && (i_apb.pready || i_apb.pslverr);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state_q      <= ST_IDLE;
      resp_valid_q <= 1'b0;
    end
    else
    begin
      resp_valid_q <= xfer_done;
      case (state_q)
        ST_IDLE:
          if (i_req.valid)
            state_q <= ST_SETUP;
        // Setup phase is held until the arbiter grants the port
        ST_SETUP:
          if (i_grant)
            state_q <= ST_ACCESS;
        ST_ACCESS:
          if (xfer_done)
            state_q <= ST_IDLE;
        default:
          state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state_q == ST_IDLE) && i_req.valid)
    begin
      paddr_q  <= i_req.addr;
      pwrite_q <= i_req.write;
      pwdata_q <= i_req.wdata;
    end
    if (xfer_done)
      resp_rdata_q <= i_apb.pslverr ? '0 : i_apb.prdata;
  end

  assign o_apb = '{paddr:   paddr_q,
                   psel:    state_q != ST_IDLE,
                   penable: state_q == ST_ACCESS,
                   pwrite:  pwrite_q,
                   pwdata:  pwdata_q};

  assign o_resp = '{valid: resp_valid_q, rdata: resp_rdata_q};

  // Access phase always follows a setup cycle
  a_penable_psel: assert property (@(posedge clk) disable iff (!reset_n)
    o_apb.penable |-> o_apb.psel && $past(o_apb.psel));

endmodule

//--- verilog/hart_bus_router.sv
/* Hart bus router
   Decodes fetch and data requests, launches them once and merges the responses */

`timescale 1ns/100ps

module hart_bus_router (
  input  logic                                                    clk,
  input  logic                                                    reset_n,
  input  mem_map_pkg::fetch_req_t                                 i_fetch_req,
  input  mem_map_pkg::data_req_t                                  i_data_req,
  input  logic                                                    i_debug_mode,
  output mem_map_pkg::bus_resp_t                                  o_fetch_resp,
  output mem_map_pkg::bus_resp_t                                  o_data_resp,
  output mem_map_pkg::ram_req_t                                   o_ram_req,
  input  logic [mem_map_pkg::XLEN-1:0]                            i_fetch_rdata,
  input  logic                                                    i_fetch_rvalid,
  input  logic [mem_map_pkg::XLEN-1:0]                            i_data_rdata,
  input  logic                                                    i_data_rvalid,
  output mem_map_pkg::apb_req_t [mem_map_pkg::NUM_APB_PORTS-1:0]  o_apb_req,
  input  mem_map_pkg::bus_resp_t [mem_map_pkg::NUM_APB_PORTS-1:0] i_apb_resp,
  output logic [mem_map_pkg::XLEN-1:0]                            o_tohost
);
  import mem_map_pkg::*;

  // Debug window wins over everything, but only in debug mode
  function automatic bus_target_e classify(input logic [XLEN-1:0] addr, input logic dbg);
    bus_target_e tgt;
    if (dbg && (addr >= DEBUG_START) && (addr <= DEBUG_END))
      tgt = TGT_DEBUG;
    else if (((addr >= RAM_BASE) && (addr < RAM_BASE + 32'(RAM_WORDS * 4))) ||
             (addr[XLEN-1:RAM_AWIDTH+2] == RAM_ALIAS_TAG))
      tgt = TGT_RAM;
    else if (addr == TOHOST_ADDR)
      tgt = TGT_TOHOST;
    else
      tgt = TGT_NONE;
    return tgt;
  endfunction

  // Per-port view, index 0 fetch and index 1 data
  logic [NUM_APB_PORTS-1:0]           req_valid;
  logic [NUM_APB_PORTS-1:0]           req_write;
  logic [NUM_APB_PORTS-1:0][XLEN-1:0] req_addr;
  logic [NUM_APB_PORTS-1:0][XLEN-1:0] req_wdata;
  bus_target_e                        tgt [NUM_APB_PORTS];
  bus_target_e                        tgt_q [NUM_APB_PORTS];
  logic [NUM_APB_PORTS-1:0]           issue;
  logic [NUM_APB_PORTS-1:0]           launched_q;
  logic [NUM_APB_PORTS-1:0]           self_valid_q;
  logic [NUM_APB_PORTS-1:0]           ram_rvalid;
  logic [NUM_APB_PORTS-1:0][XLEN-1:0] ram_rdata;
  logic [NUM_APB_PORTS-1:0]           resp_valid;
  logic [NUM_APB_PORTS-1:0][XLEN-1:0] resp_data;

  // ==================================================
  // Decode and launch
  // ==================================================
  always_comb
  begin
    req_valid = {i_data_req.valid, i_fetch_req.valid};
    req_write = {i_data_req.write, 1'b0};
    req_addr  = {i_data_req.addr, i_fetch_req.addr};
    req_wdata = {i_data_req.wdata, {XLEN{1'b0}}};
    for (int p = 0; p < NUM_APB_PORTS; p++)
    begin
      tgt[p]   = classify(req_addr[p], i_debug_mode);
      // First cycle of a new request only
      issue[p] = req_valid[p] && !launched_q[p];
      o_apb_req[p] = '{valid: issue[p] && (tgt[p] == TGT_DEBUG),
                       write: req_write[p],
                       addr:  req_addr[p][APB_AWIDTH-1:0],
                       wdata: req_wdata[p]};
    end
  end

  // Alias and base region both reduce to the low 14 address bits
  always_comb
  begin
    o_ram_req.fetch_re   = issue[0] && (tgt[0] == TGT_RAM);
    o_ram_req.fetch_idx  = req_addr[0][RAM_AWIDTH+1:2];
    o_ram_req.data_re    = issue[1] && (tgt[1] == TGT_RAM) && !req_write[1];
    o_ram_req.data_we    = issue[1] && (tgt[1] == TGT_RAM) && req_write[1];
    o_ram_req.data_idx   = req_addr[1][RAM_AWIDTH+1:2];
    o_ram_req.data_wdata = req_wdata[1];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      launched_q   <= '0;
      self_valid_q <= '0;
      o_tohost     <= '0;
      for (int p = 0; p < NUM_APB_PORTS; p++)
        tgt_q[p] <= TGT_NONE;
    end
    else
    begin
      for (int p = 0; p < NUM_APB_PORTS; p++)
      begin
        if (issue[p])
        begin
          launched_q[p] <= 1'b1;
          tgt_q[p]      <= tgt[p];
        end
        else if (resp_valid[p])
          launched_q[p] <= 1'b0;
        // Exit register and unmapped space answer after one cycle
        self_valid_q[p] <= issue[p] && ((tgt[p] == TGT_TOHOST) || (tgt[p] == TGT_NONE));
      end
      if (issue[1] && (tgt[1] == TGT_TOHOST) && req_write[1])
        o_tohost <= req_wdata[1];
    end
  end

  // ==================================================
  // Response merge
  // ==================================================
  assign ram_rvalid = {i_data_rvalid, i_fetch_rvalid};
  assign ram_rdata  = {i_data_rdata, i_fetch_rdata};

  always_comb
  begin
    for (int p = 0; p < NUM_APB_PORTS; p++)
    begin
      case (tgt_q[p])
        TGT_RAM:
        begin
          resp_valid[p] = ram_rvalid[p];
          resp_data[p]  = ram_rdata[p];
        end
        TGT_DEBUG:
        begin
          resp_valid[p] = i_apb_resp[p].valid;
          resp_data[p]  = i_apb_resp[p].rdata;
        end
        // Reads of the exit register or unmapped space give zero
        default:
        begin
          resp_valid[p] = self_valid_q[p];
          resp_data[p]  = '0;
        end
      endcase
    end
  end

  assign o_fetch_resp = '{valid: resp_valid[0], rdata: resp_data[0]};
  assign o_data_resp  = '{valid: resp_valid[1], rdata: resp_data[1]};

  // Core holds each request until its response pulse
  a_fetch_stable: assert property (@(posedge clk) disable iff (!reset_n)
    i_fetch_req.valid && !o_fetch_resp.valid |=> $stable(i_fetch_req));
  a_data_stable: assert property (@(posedge clk) disable iff (!reset_n)
    i_data_req.valid && !o_data_resp.valid |=> $stable(i_data_req));

endmodule

//--- verilog/unified_ram.sv
/* Unified single-port program RAM
   Data accesses win over fetch, reads return through a two-stage pipeline */

`timescale 1ns/100ps

module unified_ram (
  input  logic                          clk,
  input  logic                          reset_n,
  input  mem_map_pkg::ram_req_t         i_ram_req,
  output logic [mem_map_pkg::XLEN-1:0]  o_fetch_rdata,
  output logic                          o_fetch_rvalid,
  output logic [mem_map_pkg::XLEN-1:0]  o_data_rdata,
  output logic                          o_data_rvalid
);
  import mem_map_pkg::*;

  logic [XLEN-1:0] mem [RAM_WORDS];

  logic                  data_gnt;
  logic                  fetch_want;
  logic                  fetch_gnt;
  logic [RAM_AWIDTH-1:0] fetch_idx;
  logic [RAM_AWIDTH-1:0] arr_idx;
  logic                  pend_q;
  logic [RAM_AWIDTH-1:0] pend_idx_q;
  logic                  s1_fetch_q;
  logic                  s1_data_q;
  logic [XLEN-1:0]       rd_q;

  // ==================================================
  // Port arbitration
  // ==================================================
  always_comb
  begin
    data_gnt   = i_ram_req.data_re || i_ram_req.data_we;
    // A fetch that lost a cycle is replayed from the pending slot
    fetch_want = i_ram_req.fetch_re || pend_q;
    fetch_idx  = pend_q ? pend_idx_q : i_ram_req.fetch_idx;
    fetch_gnt  = fetch_want && !data_gnt;
    arr_idx    = data_gnt ? i_ram_req.data_idx : fetch_idx;
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      pend_q <= 1'b0;
    else
      pend_q <= fetch_want && data_gnt;
  end

  always_ff @(posedge clk)
  begin
    if (fetch_want && data_gnt)
      pend_idx_q <= fetch_idx;
  end

  // ==================================================
  // Array and read pipeline
  // ==================================================
  // Write-first, so a write completion carries the stored word
  always_ff @(posedge clk)
  begin
    if (i_ram_req.data_we)
    begin
      mem[arr_idx] <= i_ram_req.data_wdata;
      rd_q         <= i_ram_req.data_wdata;
    end
    else if (i_ram_req.data_re || fetch_gnt)
      rd_q <= mem[arr_idx];
  end

  // Grant owner travels alongside the read
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      s1_fetch_q     <= 1'b0;
      s1_data_q      <= 1'b0;
      o_fetch_rvalid <= 1'b0;
      o_data_rvalid  <= 1'b0;
    end
    else
    begin
      s1_fetch_q     <= fetch_gnt;
      s1_data_q      <= data_gnt;
      o_fetch_rvalid <= s1_fetch_q;
      o_data_rvalid  <= s1_data_q;
    end
  end

  // Steer stage-1 data to its port
  always_ff @(posedge clk)
  begin
    if (s1_fetch_q)
      o_fetch_rdata <= rd_q;
    if (s1_data_q)
      o_data_rdata <= rd_q;
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    !(o_fetch_rvalid && o_data_rvalid));

endmodule

//--- common/mem_map_pkg.sv
/* Memory map package for the hart memory-routing fabric
   Address map constants, bus widths and the request/response structs */

package mem_map_pkg;

  // ==================================================
  // Widths and address map
  // ==================================================
  localparam int XLEN = 32;

  // Program RAM, 16 KB of words
  localparam logic [XLEN-1:0] RAM_BASE = 32'h0001_0000;
  localparam int RAM_WORDS = 4096;
  localparam int RAM_AWIDTH = 12;
  // Upper address bits of the alias in the top 16 KB
  localparam logic [17:0] RAM_ALIAS_TAG = 18'h3FFFF;

  // Debug module window, only decoded in debug mode
  localparam logic [XLEN-1:0] DEBUG_START = 32'h0000_0200;
  localparam logic [XLEN-1:0] DEBUG_END = 32'h0000_0FFF;
  localparam int APB_AWIDTH = 13;

  // Write-only test exit register
  localparam logic [XLEN-1:0] TOHOST_ADDR = 32'h8000_1000;

  // Index 0 is fetch, index 1 is data
  localparam int NUM_APB_PORTS = 2;

  // ==================================================
  // Types
  // ==================================================
  typedef enum logic [1:0] {
    TGT_RAM,
    TGT_DEBUG,
    TGT_TOHOST,
    TGT_NONE
  } bus_target_e;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic            valid;
    logic            write;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } data_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] rdata;
  } bus_resp_t;

  // One request handed to an APB requester
  typedef struct packed {
    logic                  valid;
    logic                  write;
    logic [APB_AWIDTH-1:0] addr;
    logic [XLEN-1:0]       wdata;
  } apb_req_t;

  typedef struct packed {
    logic                  fetch_re;
    logic [RAM_AWIDTH-1:0] fetch_idx;
    logic                  data_re;
    logic                  data_we;
    logic [RAM_AWIDTH-1:0] data_idx;
    logic [XLEN-1:0]       data_wdata;
  } ram_req_t;

  typedef struct packed {
    logic [APB_AWIDTH-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [XLEN-1:0]       pwdata;
  } apb_m2s_t;

  typedef struct packed {
    logic            pready;
    logic [XLEN-1:0] prdata;
    logic            pslverr;
  } apb_s2m_t;

endpackage
